/* hdl/calc_pkg.sv */
package calc_pkg;

    localparam int KEY_COLS = 4;                 // keypad columns, driven low one at a time
    localparam int KEY_ROWS = 4;                 // keypad rows, pulled up
    localparam int KEY_NUM  = KEY_ROWS * KEY_COLS;

    typedef enum logic [2:0] {
        KEY_DIGIT,                               // 0..9 in digit field
        KEY_OP,                                  // operator in op field
        KEY_EQUAL,
        KEY_CLEAR,
        KEY_SIGN                                 // negate current entry
    } key_kind_t;

    typedef enum logic [1:0] {
        OP_NONE,                                 // nothing pending
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;                       // only meaningful for KEY_DIGIT
        op_t        op;                          // only meaningful for KEY_OP
    } key_event_t;

    // key index = row * KEY_COLS + col
    localparam key_event_t KEY_MAP [KEY_NUM] = '{
        '{KEY_DIGIT, 4'd1, OP_NONE}, '{KEY_DIGIT, 4'd2, OP_NONE},    // 0, 1
        '{KEY_DIGIT, 4'd3, OP_NONE}, '{KEY_OP,    4'd0, OP_ADD },    // 2, 3
        '{KEY_DIGIT, 4'd4, OP_NONE}, '{KEY_DIGIT, 4'd5, OP_NONE},    // 4, 5
        '{KEY_DIGIT, 4'd6, OP_NONE}, '{KEY_OP,    4'd0, OP_SUB },    // 6, 7
        '{KEY_DIGIT, 4'd7, OP_NONE}, '{KEY_DIGIT, 4'd8, OP_NONE},    // 8, 9
        '{KEY_DIGIT, 4'd9, OP_NONE}, '{KEY_OP,    4'd0, OP_MUL },    // 10, 11
        '{KEY_EQUAL, 4'd0, OP_NONE}, '{KEY_DIGIT, 4'd0, OP_NONE},    // 12, 13
        '{KEY_CLEAR, 4'd0, OP_NONE}, '{KEY_SIGN,  4'd0, OP_NONE}     // 14, 15
    };

endpackage

/* hdl/keypad_scan.sv */
`timescale 1ns/1ps

module keypad_scan #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::KEY_ROWS-1:0] row_in,     // low = key in driven column
    output logic [calc_pkg::KEY_COLS-1:0] col_out,    // one bit low
    input  logic                          key_ack,    // one-cycle pulse from controller
    output logic                          key_ready,  // level, holds until ack
    output calc_pkg::key_event_t          key_event
);

    localparam int COL_W = $clog2(calc_pkg::KEY_COLS);
    localparam int ROW_W = $clog2(calc_pkg::KEY_ROWS);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        SCAN,                                    // walk columns until a row goes low
        DEBOUNCE,                                // column frozen, count stable cycles
        READY,                                   // event presented, wait for ack
        RELEASE                                  // wait for all rows high
    } state_t;

    state_t                     state;
    logic [COL_W-1:0]           col_idx;
    logic [CNT_W-1:0]           deb_cnt;
    logic [calc_pkg::KEY_ROWS-1:0] row_hold;    // row pattern seen at press
    logic [ROW_W-1:0]           row_idx;
    logic [ROW_W+COL_W-1:0]     key_idx;
    logic                       row_low;

    assign row_low   = ~&row_in;                 // any row pulled low
    assign key_ready = (state == READY);

    // column drive, active low
    always_comb begin
        col_out = '1;
        col_out[col_idx] = 1'b0;
    end

    // lowest low row wins if several are down
    always_comb begin
        row_idx = '0;
        for (int r = calc_pkg::KEY_ROWS - 1; r >= 0; r--) begin
            if (!row_hold[r]) begin
                row_idx = r[ROW_W-1:0];
            end
        end
    end

    assign key_idx = {row_idx, col_idx};         // row * 4 + col

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= SCAN;
            col_idx <= '0;
            deb_cnt <= '0;
        end else begin
            case (state)
                SCAN: begin
                    if (row_low) begin
                        state   <= DEBOUNCE;     // freeze column here
                        deb_cnt <= CNT_W'(1);    // this cycle counts
                    end else begin
                        col_idx <= col_idx + 1'b1;   // wraps over 4 columns
                    end
                end
                DEBOUNCE: begin
                    if (row_in != row_hold) begin
                        state   <= SCAN;         // bounce, start over
                        deb_cnt <= '0;
                    end else if (deb_cnt >= CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                        state   <= READY;
                        deb_cnt <= '0;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                READY: begin
                    if (key_ack) begin
                        state <= RELEASE;        // key_ready drops next clock
                    end
                end
                RELEASE: begin
                    if (!row_low) begin
                        state <= SCAN;           // re-armed
                    end
                end
                default: state <= SCAN;
            endcase
        end
    end

    // press pattern and decoded event
    always_ff @(posedge clk) begin
        if (state == SCAN && row_low) begin
            row_hold <= row_in;
        end
        if (state == DEBOUNCE && row_in == row_hold &&
            deb_cnt >= CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            key_event <= calc_pkg::KEY_MAP[key_idx];
        end
    end

    // exactly one column driven low, in every state
    a_one_col: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out));

    // event stays put until the controller has taken it
    a_hold_event: assert property (@(posedge clk) disable iff (!nRST)
        key_ready && !key_ack |=> key_ready && $stable(key_event));

endmodule

/* hdl/calc_control.sv */
`timescale 1ns/1ps

module calc_control #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_ready,
    input  calc_pkg::key_event_t     key_event,
    output logic                     key_ack,       // one-cycle pulse
    output logic signed [DATA_W-1:0] operand_a,     // accumulator at equals
    output logic signed [DATA_W-1:0] operand_b,     // entry at equals
    output calc_pkg::op_t            op,
    output logic                     start,
    input  logic signed [DATA_W-1:0] result,
    input  logic                     alu_overflow,
    input  logic                     done,
    output logic signed [DATA_W-1:0] display,
    output logic                     overflow,
    output logic                     result_valid
);

    logic signed [DATA_W-1:0] entry;             // number being typed
    logic signed [DATA_W-1:0] acc;               // running accumulator
    logic signed [DATA_W-1:0] entry_digit;       // entry with next digit shifted in
    calc_pkg::op_t            pend_op;           // operator waiting for equals
    logic                     has_entry;         // digits typed since last op/equals
    logic                     alu_busy;          // start issued, done not yet seen
    logic                     run_alu;

    // wraps modulo 2**DATA_W
    assign entry_digit = entry * DATA_W'(10) + DATA_W'(key_event.digit);
    assign run_alu = key_ack && key_event.kind == calc_pkg::KEY_EQUAL &&
                     pend_op != calc_pkg::OP_NONE;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_ack      <= 1'b0;
            start        <= 1'b0;
            result_valid <= 1'b0;
            alu_busy     <= 1'b0;
            entry        <= '0;
            acc          <= '0;
            display      <= '0;
            overflow     <= 1'b0;
            has_entry    <= 1'b0;
            pend_op      <= calc_pkg::OP_NONE;
        end else begin
            key_ack      <= key_ready && !key_ack && !alu_busy;
            start        <= run_alu;
            result_valid <= 1'b0;
            if (done) begin                      // alu answer, third cycle after ack
                acc          <= result;
                display      <= result;
                overflow     <= alu_overflow;
                result_valid <= 1'b1;
                alu_busy     <= 1'b0;
            end
            if (key_ack) begin                   // act in the ack cycle
                case (key_event.kind)
                    calc_pkg::KEY_DIGIT: begin
                        entry     <= entry_digit;
                        display   <= entry_digit;
                        has_entry <= 1'b1;
                    end
                    calc_pkg::KEY_SIGN: begin
                        entry   <= -entry;
                        display <= -entry;
                    end
                    calc_pkg::KEY_CLEAR: begin
                        entry     <= '0;
                        acc       <= '0;
                        display   <= '0;
                        overflow  <= 1'b0;
                        has_entry <= 1'b0;
                        pend_op   <= calc_pkg::OP_NONE;
                    end
                    calc_pkg::KEY_OP: begin
                        // no entry typed: keep last result as left operand
                        if (pend_op == calc_pkg::OP_NONE && has_entry) begin
                            acc <= entry;
                        end
                        pend_op   <= key_event.op;
                        entry     <= '0;
                        display   <= '0;
                        has_entry <= 1'b0;
                    end
                    calc_pkg::KEY_EQUAL: begin
                        if (pend_op != calc_pkg::OP_NONE) begin
                            alu_busy <= 1'b1;
                        end else begin   // bare equals, entry becomes result
                            acc          <= entry;
                            display      <= entry;
                            overflow     <= 1'b0;
                            result_valid <= 1'b1;
                        end
                        pend_op   <= calc_pkg::OP_NONE;
                        entry     <= '0;
                        has_entry <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    // operands captured with start
    always_ff @(posedge clk) begin
        if (run_alu) begin
            operand_a <= acc;
            operand_b <= entry;
            op        <= pend_op;
        end
    end

endmodule

/* hdl/calc_alu.sv */
`timescale 1ns/1ps

module calc_alu #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     start,      // one-cycle pulse
    input  calc_pkg::op_t            op,
    input  logic signed [DATA_W-1:0] operand_a,
    input  logic signed [DATA_W-1:0] operand_b,
    output logic signed [DATA_W-1:0] result,     // truncated
    output logic                     overflow,   // full value did not fit
    output logic                     done        // one clock after start
);

    logic signed [2*DATA_W-1:0] full;            // wide enough for the product
    logic [DATA_W:0]            top_bits;        // must be all 0 or all 1
    logic                       wrap;

    always_comb begin
        case (op)
            calc_pkg::OP_ADD: full = operand_a + operand_b;   // sign extended first
            calc_pkg::OP_SUB: full = operand_a - operand_b;
            calc_pkg::OP_MUL: full = operand_a * operand_b;
            default:          full = operand_a;               // pass left operand
        endcase
    end

    assign top_bits = full[2*DATA_W-1:DATA_W-1];
    assign wrap     = !(&top_bits || ~|top_bits);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result   <= full[DATA_W-1:0];
            overflow <= wrap;
        end
    end

    // add and sub wrap exactly when the operands agree in sign and the result does not
    a_addsub_ovf: assert property (@(posedge clk) disable iff (!nRST)
        start && (op == calc_pkg::OP_ADD || op == calc_pkg::OP_SUB) |=>
        done && overflow == ($past(operand_a[DATA_W-1]) != result[DATA_W-1] &&
                             $past(operand_a[DATA_W-1]) ==
                             ($past(operand_b[DATA_W-1]) ^
                              ($past(op) == calc_pkg::OP_SUB))));

endmodule

/* hdl/calc_top.sv */
`timescale 1ns/1ps

module calc_top #(
    parameter int DEBOUNCE_CYCLES = 500000,      // ~stable press time in clocks
    parameter int DATA_W          = 16
) (
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [calc_pkg::KEY_ROWS-1:0] row_in,
    output logic [calc_pkg::KEY_COLS-1:0] col_out,
    output logic signed [DATA_W-1:0]      display,
    output logic                          overflow,
    output logic                          result_valid
);

    logic                     key_ready;
    logic                     key_ack;
    calc_pkg::key_event_t     key_event;
    logic signed [DATA_W-1:0] operand_a;
    logic signed [DATA_W-1:0] operand_b;
    calc_pkg::op_t            alu_op;
    logic                     start;
    logic signed [DATA_W-1:0] alu_result;
    logic                     alu_overflow;
    logic                     done;

    keypad_scan #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_keypad_scan (
        .clk, .nRST, .row_in, .col_out, .key_ack, .key_ready, .key_event
    );

    calc_control #(.DATA_W(DATA_W)) i_calc_control (
        .clk, .nRST, .key_ready, .key_event, .key_ack,
        .operand_a, .operand_b, .op(alu_op), .start,
        .result(alu_result), .alu_overflow, .done,
        .display, .overflow, .result_valid
    );

    calc_alu #(.DATA_W(DATA_W)) i_calc_alu (
        .clk, .nRST, .start, .op(alu_op), .operand_a, .operand_b,
        .result(alu_result), .overflow(alu_overflow), .done
    );

endmodule

/* bench/keypad_model.sv */
`timescale 1ns/1ps

module keypad_model (
    input  logic [calc_pkg::KEY_COLS-1:0] col_out,   // scanner drives one column low
    input  logic                          pressed,   // contact closed
    input  logic [3:0]                    key,       // row * 4 + col
    output logic [calc_pkg::KEY_ROWS-1:0] row_in     // pulled up when open
);

    logic [1:0] key_row;
    logic [1:0] key_col;

    assign key_row = key[3:2];
    assign key_col = key[1:0];

    // closed contact shorts its row to its column
    always_comb begin
        row_in = '1;
        if (pressed && !col_out[key_col]) begin
            row_in[key_row] = 1'b0;
        end
    end

endmodule

/* bench/tb_calc.sv */
`timescale 1ns/1ps

module tb_calc;

    localparam int    DATA_W          = 16;
    localparam int    DEBOUNCE_CYCLES = 16;
    localparam int    SEED            = 86081;
    localparam int    LIMIT           = 400;        // cycles allowed per wait
    localparam int    VMAX            = 2 ** (DATA_W - 1) - 1;
    localparam string KEYS            = "123+456-789*=0cs";   // legend by key index

    logic                          clk;
    logic                          nRST;
    logic [calc_pkg::KEY_ROWS-1:0] row_in;
    logic [calc_pkg::KEY_COLS-1:0] col_out;
    logic signed [DATA_W-1:0]      display;
    logic                          overflow;
    logic                          result_valid;
    logic                          pressed;
    logic [3:0]                    key;
    logic signed [DATA_W-1:0]      m_entry     = '0;   // reference model
    logic signed [DATA_W-1:0]      m_acc       = '0;
    calc_pkg::op_t                 m_op        = calc_pkg::OP_NONE;
    logic                          m_has       = 1'b0;
    logic signed [DATA_W-1:0]      exp_display = '0;
    logic                          exp_ovf     = 1'b0;
    logic                          settled     = 1'b1; // outputs must match model
    logic                          rv_armed    = 1'b0; // result pulse allowed
    int                            ack_count   = 0;
    int                            rv_count    = 0;
    int                            err_count   = 0;
    int                            to_count    = 0;
    logic [31:0]                   rng         = SEED;
    string                         test_name   = "reset";

    calc_top #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .DATA_W(DATA_W)) i_calc_top (
        .clk, .nRST, .row_in, .col_out, .display, .overflow, .result_valid
    );

    keypad_model i_keypad_model (.col_out, .pressed, .key, .row_in);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    always @(posedge clk) begin
        ack_count <= ack_count + int'(i_calc_top.key_ack);   // keys taken
        rv_count  <= rv_count + int'(result_valid);
    end

    a_display: assert property (@(posedge clk) disable iff (!nRST)
        settled |-> display == exp_display && overflow == exp_ovf)
        else begin
            $display("ERR %s display/overflow expected %0d/%0b actual %0d/%0b",
                     test_name, exp_display, exp_ovf, $sampled(display), $sampled(overflow));
            err_count++;
        end

    a_result: assert property (@(posedge clk) disable iff (!nRST) result_valid |-> rv_armed)
        else begin
            $display("result_valid pulsed in %s where no result was due", test_name);
            err_count++;
        end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic expect_equal(input string what, input int want, input int got);
        assert (want == got) else begin
            $display("ERR %s %s expected %0d actual %0d", test_name, what, want, got);
            err_count++;
        end
    endtask

    task automatic model_key(input byte c);
        int full;
        int dig;
        dig = c - "0";
        case (c)
            "s": m_entry = -m_entry;
            "c": begin
                m_acc   = '0;
                m_op    = calc_pkg::OP_NONE;
                exp_ovf = 1'b0;
            end
            "=": begin
                case (m_op)
                    calc_pkg::OP_ADD: full = m_acc + m_entry;
                    calc_pkg::OP_SUB: full = m_acc - m_entry;
                    calc_pkg::OP_MUL: full = m_acc * m_entry;
                    default:          full = m_entry;        // bare equals
                endcase
                m_acc   = full[DATA_W-1:0];                 // wraps modulo 2**DATA_W
                exp_ovf = full > VMAX || full < -VMAX - 1;
                m_op    = calc_pkg::OP_NONE;
            end
            "+", "-", "*": begin
                if (m_op == calc_pkg::OP_NONE && m_has) begin
                    m_acc = m_entry;                        // else continue from result
                end
                m_op = (c == "+") ? calc_pkg::OP_ADD :
                       (c == "-") ? calc_pkg::OP_SUB : calc_pkg::OP_MUL;
            end
            default: begin
                m_entry = m_entry * 10 + dig;               // digit, wraps too
                m_has   = 1'b1;
            end
        endcase
        if (c inside {"+", "-", "*", "=", "c"}) begin
            exp_display = (c == "=") ? m_acc : '0;
            m_entry     = '0;
            m_has       = 1'b0;
        end else begin
            exp_display = m_entry;                          // digits and sign
        end
    endtask

    // contact closed for less than one debounce period
    task automatic contact_pulse();
        rng     = xorshift(rng);
        pressed = 1'b1;
        repeat (1 + rng % 14) @(negedge clk);
        rng     = xorshift(rng);
        pressed = 1'b0;
        repeat (1 + rng % 6) @(negedge clk);
    endtask

    task automatic release_gap();
        int quiet;
        int t;
        quiet = 0;
        for (t = 0; t < LIMIT && quiet < 8; t++) begin       // rows idle so scanner re-arms
            @(negedge clk);
            quiet = (&row_in) ? quiet + 1 : 0;
        end
        if (quiet < 8) begin
            $display("timeout in %s: rows never went idle after release", test_name);
            to_count++;
        end
    endtask

    task automatic press(input int idx, input bit bounce = 1'b0, input int hold = 0);
        int t;
        int n_ack;
        int n_rv;
        bit is_eq;
        n_ack    = ack_count;
        n_rv     = rv_count;
        is_eq    = (KEYS[idx] == "=");
        settled  = 1'b0;
        rv_armed = is_eq;
        key      = idx[3:0];
        if (bounce) begin
            repeat (3) contact_pulse();                     // chatter before contact settles
        end
        pressed = 1'b1;
        t = 0;
        while ((ack_count == n_ack || (is_eq && rv_count == n_rv)) && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (t >= LIMIT) begin
            $display("timeout in %s: key %0d never took effect", test_name, idx);
            to_count++;
        end
        model_key(KEYS[idx]);
        settled  = 1'b1;
        rv_armed = 1'b0;
        repeat (hold) @(negedge clk);
        pressed = 1'b0;
        release_gap();
        expect_equal("key events", 1, ack_count - n_ack);
        expect_equal("result pulses", int'(is_eq), rv_count - n_rv);
    endtask

    task automatic glitch(input int idx);
        int n_ack;
        n_ack = ack_count;
        key   = idx[3:0];
        contact_pulse();
        release_gap();
        expect_equal("glitch key events", 0, ack_count - n_ack);
    endtask

    task automatic type_keys(input string s);
        for (int i = 0; i < s.len(); i++) begin
            for (int k = 0; k < calc_pkg::KEY_NUM; k++) begin
                if (KEYS[k] == s[i]) begin
                    press(k);
                end
            end
        end
    endtask

    initial begin
        nRST    = 1'b0;
        pressed = 1'b0;
        key     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        assert ($onehot(~col_out)) else begin
            $display("col_out does not drive exactly one column low after reset");
            err_count++;
        end
        test_name = "digit_entry";
        type_keys("123");
        for (int i = 0; i < calc_pkg::KEY_NUM; i++) begin
            press(i);                                       // every key position
        end
        test_name = "arithmetic";
        type_keys("c12+30=5-9=7*6=*2=");                    // last op continues from 42
        test_name = "sign_clear";
        type_keys("25sc");
        test_name = "debounce";
        press(1, 1'b1);                                     // chattering 2
        glitch(5);
        press(2, 1'b0, 6 * DEBOUNCE_CYCLES);                // 3 held for six periods
        test_name = "overflow";
        type_keys("c300*300=c");
        $display("errors: %0d, timeouts: %0d", err_count, to_count);
        if (err_count == 0 && to_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/calc_pkg.sv
hdl/keypad_scan.sv
hdl/calc_control.sv
hdl/calc_alu.sv
hdl/calc_top.sv
bench/keypad_model.sv
bench/tb_calc.sv
